// File: rtl/rfcop_pkg.sv
// Shared types and constants for the register-file coprocessor
// Register index, opcode and APB address types, opcode values,
// APB address map, command word field positions, decode state enum
package rfcop_pkg;

  // ------------------------------------------------------------
  // Basic types
  // ------------------------------------------------------------
  // Index into the 32-entry register space, entry 0 reads zero
  typedef logic [4:0] reg_addr_t;
  // Command opcode
  typedef logic [2:0] op_t;
  // APB byte address
  typedef logic [11:0] apb_addr_t;

  // ------------------------------------------------------------
  // Opcodes
  // ------------------------------------------------------------
  localparam op_t OP_ADD  = 3'd0;
  localparam op_t OP_SUB  = 3'd1;
  localparam op_t OP_AND  = 3'd2;
  localparam op_t OP_OR   = 3'd3;
  localparam op_t OP_XOR  = 3'd4;
  localparam op_t OP_SLL  = 3'd5;
  // Three-operand add and conditional select on bit 0 of rs3
  localparam op_t OP_ADD3 = 3'd6;
  localparam op_t OP_CSEL = 3'd7;

  // ------------------------------------------------------------
  // APB map
  // ------------------------------------------------------------
  localparam apb_addr_t ADDR_CMD   = 12'h000;
  localparam apb_addr_t ADDR_LAST  = 12'h004;
  localparam apb_addr_t ADDR_COUNT = 12'h008;
  // Register n sits at REG_BASE + 4*n
  localparam apb_addr_t REG_BASE   = 12'h100;

  // Command word field positions (LSB of each field)
  localparam int CMD_OP_LSB  = 0;
  localparam int CMD_RD_LSB  = 5;
  localparam int CMD_RS1_LSB = 10;
  localparam int CMD_RS2_LSB = 15;
  localparam int CMD_RS3_LSB = 20;

  // Decode FSM, busy from command issue until write-back
  typedef enum logic {DEC_IDLE, DEC_BUSY} dec_state_e;

endpackage

// File: rtl/clock_gate.sv
// Latch-based clock gate with test enable
// Used for the global write gate and every per-word gate
module clock_gate (
  input  logic clk_i,
  input  logic en_i,
  input  logic test_en_i,
  output logic clk_o
);

  logic en_latched;

  // Enable only changes while the clock is low, so no glitch on clk_o
  always_latch
  begin : en_latch
    if (!clk_i)
      en_latched = en_i | test_en_i;
  end

  // Gated clock
  assign clk_o = clk_i & en_latched;

endmodule

// File: rtl/register_file.sv
// Latch-based register file, 31 words plus hardwired zero
// Three combinational read ports and two write ports
// Write address decoders, global and per-word clock gating, input sampling
module register_file import rfcop_pkg::*; #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_n,
  input  logic                  test_en_i,

  // Read ports
  input  reg_addr_t             raddr_a_i,
  input  reg_addr_t             raddr_b_i,
  input  reg_addr_t             raddr_c_i,
  output logic [DATA_WIDTH-1:0] rdata_a_o,
  output logic [DATA_WIDTH-1:0] rdata_b_o,
  output logic [DATA_WIDTH-1:0] rdata_c_o,

  // Write port A, command write-back
  input  reg_addr_t             waddr_a_i,
  input  logic [DATA_WIDTH-1:0] wdata_a_i,
  input  logic                  we_a_i,

  // Write port B, direct host writes
  input  reg_addr_t             waddr_b_i,
  input  logic [DATA_WIDTH-1:0] wdata_b_i,
  input  logic                  we_b_i
);

  localparam int NUM_WORDS = 2 ** $bits(reg_addr_t);

  // Storage, word 0 is not stored
  logic [DATA_WIDTH-1:0] mem [1:NUM_WORDS-1];

  logic [NUM_WORDS-1:1]  onehot_a;
  logic [NUM_WORDS-1:1]  onehot_b;
  logic [NUM_WORDS-1:1]  onehot_b_q;
  logic [NUM_WORDS-1:1]  word_clk;
  logic [DATA_WIDTH-1:0] wdata_a_q;
  logic [DATA_WIDTH-1:0] wdata_b_q;
  logic                  clk_gated;

  // Onehot word select for one write port, word 0 never selected
  function automatic logic [NUM_WORDS-1:1] word_select(input reg_addr_t addr,
                                                       input logic      we);
    logic [NUM_WORDS-1:1] sel;
    sel = '0;
    for (int w = 1; w < NUM_WORDS; w++)
    begin
      sel[w] = we && (addr == reg_addr_t'(w));
    end
    return sel;
  endfunction

  // ------------------------------------------------------------
  // Read ports
  // ------------------------------------------------------------
  // Index 0 reads zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : mem[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : mem[raddr_b_i];
  assign rdata_c_o = (raddr_c_i == '0) ? '0 : mem[raddr_c_i];

  // ------------------------------------------------------------
  // Write address decoders
  // ------------------------------------------------------------
  always_comb
  begin : wad
    onehot_a = word_select(waddr_a_i, we_a_i);
    onehot_b = word_select(waddr_b_i, we_b_i);
  end

  // ------------------------------------------------------------
  // Global gate and input sampling
  // ------------------------------------------------------------
  // Sampling clock only runs when some port writes
  clock_gate u_cg_global (
    .clk_i     (clk_i),
    .en_i      (we_a_i | we_b_i),
    .test_en_i (test_en_i),
    .clk_o     (clk_gated)
  );

  // Port B selection, kept for the latch phase after the edge
  always_ff @(posedge clk_gated, negedge rst_n)
  begin : sample_sel
    if (!rst_n)
      onehot_b_q <= '0;
    else
      onehot_b_q <= onehot_b;
  end

  // Write data, held stable while the word latch is open
  always_ff @(posedge clk_gated)
  begin : sample_data
    if (we_a_i)
      wdata_a_q <= wdata_a_i;
    if (we_b_i)
      wdata_b_q <= wdata_b_i;
  end

  // ------------------------------------------------------------
  // Per-word gates
  // ------------------------------------------------------------
  for (genvar x = 1; x < NUM_WORDS; x++)
  begin : g_word_cg
    clock_gate u_cg_word (
      .clk_i     (clk_gated),
      .en_i      (onehot_a[x] | onehot_b[x]),
      .test_en_i (test_en_i),
      .clk_o     (word_clk[x])
    );
  end

  // ------------------------------------------------------------
  // Word latches
  // ------------------------------------------------------------
  // Transparent while the word clock is high, port B wins on a tie
  always_latch
  begin : word_latches
    for (int k = 1; k < NUM_WORDS; k++)
    begin
      if (!rst_n)
        mem[k] = '0;
      else if (word_clk[k])
        mem[k] = onehot_b_q[k] ? wdata_b_q : wdata_a_q;
    end
  end

endmodule

// File: rtl/apb_cmd_decode.sv
// APB slave and command decode stage
// Busy FSM driving PREADY, command field registers,
// direct register write path and read-data mux
module apb_cmd_decode import rfcop_pkg::*; #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_n,

  // APB slave
  input  apb_addr_t             paddr_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [DATA_WIDTH-1:0] pwdata_i,
  output logic [DATA_WIDTH-1:0] prdata_o,
  output logic                  pready_o,

  // Register file read and port B
  output reg_addr_t             raddr_a_o,
  output reg_addr_t             raddr_b_o,
  output reg_addr_t             raddr_c_o,
  input  logic [DATA_WIDTH-1:0] rdata_c_i,
  output reg_addr_t             waddr_b_o,
  output logic [DATA_WIDTH-1:0] wdata_b_o,
  output logic                  we_b_o,

  // To execute
  output logic                  op_valid_o,
  output op_t                   op_o,
  output reg_addr_t             rd_o,

  // From write-back
  input  logic [DATA_WIDTH-1:0] last_result_i,
  input  logic [DATA_WIDTH-1:0] retire_count_i,
  input  logic                  wb_done_i
);

  dec_state_e state_q;
  dec_state_e state_d;
  logic       access_done;
  logic       cmd_wr;
  logic       reg_sel;
  reg_addr_t  apb_reg_idx;
  reg_addr_t  rs1_q;
  reg_addr_t  rs2_q;
  reg_addr_t  rs3_q;

  // ------------------------------------------------------------
  // Address decode
  // ------------------------------------------------------------
  assign pready_o    = (state_q == DEC_IDLE);
  assign access_done = psel_i & penable_i & pready_o;
  // Word-aligned hits in the 128-byte register window
  assign reg_sel     = (paddr_i[11:7] == REG_BASE[11:7]) && (paddr_i[1:0] == 2'b00);
  assign apb_reg_idx = paddr_i[6:2];
  assign cmd_wr      = access_done & pwrite_i & (paddr_i == ADDR_CMD);

  // ------------------------------------------------------------
  // Busy FSM
  // ------------------------------------------------------------
  always_comb
  begin : next_state
    state_d = state_q;
    case (state_q)
      DEC_IDLE: if (cmd_wr) state_d = DEC_BUSY;
      DEC_BUSY: if (wb_done_i) state_d = DEC_IDLE;
      default:  state_d = DEC_IDLE;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_n)
  begin : ctrl_regs
    if (!rst_n)
    begin
      state_q    <= DEC_IDLE;
      op_valid_o <= 1'b0;
    end
    else
    begin
      state_q    <= state_d;
      // One-cycle issue pulse
      op_valid_o <= cmd_wr;
    end
  end

  // Command fields, captured at issue
  always_ff @(posedge clk_i)
  begin : field_regs
    if (cmd_wr)
    begin
      op_o  <= pwdata_i[CMD_OP_LSB  +: $bits(op_t)];
      rd_o  <= pwdata_i[CMD_RD_LSB  +: $bits(reg_addr_t)];
      rs1_q <= pwdata_i[CMD_RS1_LSB +: $bits(reg_addr_t)];
      rs2_q <= pwdata_i[CMD_RS2_LSB +: $bits(reg_addr_t)];
      rs3_q <= pwdata_i[CMD_RS3_LSB +: $bits(reg_addr_t)];
    end
  end

  // ------------------------------------------------------------
  // Register file side
  // ------------------------------------------------------------
  assign raddr_a_o = rs1_q;
  assign raddr_b_o = rs2_q;
  // Port C is shared, rs3 while busy, host reads otherwise
  assign raddr_c_o = (state_q == DEC_BUSY) ? rs3_q : apb_reg_idx;

  // Direct writes, register 0 is dropped inside the register file
  assign waddr_b_o = apb_reg_idx;
  assign wdata_b_o = pwdata_i;
  assign we_b_o    = access_done & pwrite_i & reg_sel;

  // Read data mux, unmapped addresses read zero
  always_comb
  begin : rdata_mux
    prdata_o = '0;
    if (reg_sel)
      prdata_o = rdata_c_i;
    else if (paddr_i == ADDR_LAST)
      prdata_o = last_result_i;
    else if (paddr_i == ADDR_COUNT)
      prdata_o = retire_count_i;
  end

endmodule

// File: rtl/alu_execute.sv
// Execute stage with a registered three-operand ALU
// Forwards the destination index and a one-cycle result valid
module alu_execute import rfcop_pkg::*; #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_n,
  input  logic                  op_valid_i,
  input  op_t                   op_i,
  input  reg_addr_t             rd_i,
  input  logic [DATA_WIDTH-1:0] opa_i,
  input  logic [DATA_WIDTH-1:0] opb_i,
  input  logic [DATA_WIDTH-1:0] opc_i,
  output logic                  res_valid_o,
  output reg_addr_t             res_rd_o,
  output logic [DATA_WIDTH-1:0] res_data_o
);

  logic [DATA_WIDTH-1:0] alu_res;

  // ------------------------------------------------------------
  // ALU, all arithmetic wraps
  // ------------------------------------------------------------
  always_comb
  begin : alu
    unique case (op_i)
      OP_ADD:  alu_res = opa_i + opb_i;
      OP_SUB:  alu_res = opa_i - opb_i;
      OP_AND:  alu_res = opa_i & opb_i;
      OP_OR:   alu_res = opa_i | opb_i;
      OP_XOR:  alu_res = opa_i ^ opb_i;
      // Shift amount from the low 5 bits of b
      OP_SLL:  alu_res = opa_i << opb_i[4:0];
      OP_ADD3: alu_res = opa_i + opb_i + opc_i;
      OP_CSEL: alu_res = opc_i[0] ? opa_i : opb_i;
    endcase
  end

  // ------------------------------------------------------------
  // Result register
  // ------------------------------------------------------------
  always_ff @(posedge clk_i, negedge rst_n)
  begin : valid_reg
    if (!rst_n)
      res_valid_o <= 1'b0;
    else
      res_valid_o <= op_valid_i;
  end

  // Payload only loads on an issued command
  always_ff @(posedge clk_i)
  begin : data_reg
    if (op_valid_i)
    begin
      res_rd_o   <= rd_i;
      res_data_o <= alu_res;
    end
  end

endmodule

// File: rtl/result_writeback.sv
// Write-back stage
// Drives register file port A, keeps the last result and
// counts retired commands
module result_writeback import rfcop_pkg::*; #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_n,
  input  logic                  res_valid_i,
  input  reg_addr_t             res_rd_i,
  input  logic [DATA_WIDTH-1:0] res_data_i,
  output logic                  we_a_o,
  output reg_addr_t             waddr_a_o,
  output logic [DATA_WIDTH-1:0] wdata_a_o,
  output logic [DATA_WIDTH-1:0] last_result_o,
  output logic [DATA_WIDTH-1:0] retire_count_o,
  output logic                  wb_done_o
);

  // ------------------------------------------------------------
  // Port A write
  // ------------------------------------------------------------
  // Write-back cycle is the cycle the execute register holds its valid
  // Register file samples it at the following edge
  assign we_a_o    = res_valid_i;
  assign waddr_a_o = res_rd_i;
  assign wdata_a_o = res_data_i;

  // Decode leaves busy at the same edge
  assign wb_done_o = res_valid_i;

  // ------------------------------------------------------------
  // Status registers
  // ------------------------------------------------------------
  // Counts every retired command, rd 0 included
  always_ff @(posedge clk_i, negedge rst_n)
  begin : status_regs
    if (!rst_n)
    begin
      last_result_o  <= '0;
      retire_count_o <= '0;
    end
    else if (res_valid_i)
    begin
      last_result_o  <= res_data_i;
      retire_count_o <= retire_count_o + 1'b1;
    end
  end

endmodule

// File: rtl/rfcop_top.sv
// Coprocessor top level
// APB decode, register file, execute and write-back stages
module rfcop_top import rfcop_pkg::*; #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk_int,
  input  logic                  rst_n,
  input  logic                  test_en_i,

  // APB slave
  input  apb_addr_t             paddr_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [DATA_WIDTH-1:0] pwdata_i,
  output logic [DATA_WIDTH-1:0] prdata_o,
  output logic                  pready_o
);

  // Register file read side
  reg_addr_t             raddr_a;
  reg_addr_t             raddr_b;
  reg_addr_t             raddr_c;
  logic [DATA_WIDTH-1:0] rdata_a;
  logic [DATA_WIDTH-1:0] rdata_b;
  logic [DATA_WIDTH-1:0] rdata_c;

  // Write ports
  reg_addr_t             waddr_a;
  logic [DATA_WIDTH-1:0] wdata_a;
  logic                  we_a;
  reg_addr_t             waddr_b;
  logic [DATA_WIDTH-1:0] wdata_b;
  logic                  we_b;

  // Pipeline
  logic                  op_valid;
  op_t                   op;
  reg_addr_t             op_rd;
  logic                  res_valid;
  reg_addr_t             res_rd;
  logic [DATA_WIDTH-1:0] res_data;

  // Write-back status
  logic [DATA_WIDTH-1:0] last_result;
  logic [DATA_WIDTH-1:0] retire_count;
  logic                  wb_done;

  // ------------------------------------------------------------
  // Decode and APB slave
  // ------------------------------------------------------------
  apb_cmd_decode #(.DATA_WIDTH(DATA_WIDTH)) u_decode (
    .clk_i (clk_int), .rst_n (rst_n),
    .paddr_i (paddr_i), .psel_i (psel_i), .penable_i (penable_i),
    .pwrite_i (pwrite_i), .pwdata_i (pwdata_i),
    .prdata_o (prdata_o), .pready_o (pready_o),
    .raddr_a_o (raddr_a), .raddr_b_o (raddr_b), .raddr_c_o (raddr_c),
    .rdata_c_i (rdata_c),
    .waddr_b_o (waddr_b), .wdata_b_o (wdata_b), .we_b_o (we_b),
    .op_valid_o (op_valid), .op_o (op), .rd_o (op_rd),
    .last_result_i (last_result), .retire_count_i (retire_count),
    .wb_done_i (wb_done)
  );

  // ------------------------------------------------------------
  // Register file
  // ------------------------------------------------------------
  register_file #(.DATA_WIDTH(DATA_WIDTH)) u_regfile (
    .clk_i (clk_int), .rst_n (rst_n), .test_en_i (test_en_i),
    .raddr_a_i (raddr_a), .raddr_b_i (raddr_b), .raddr_c_i (raddr_c),
    .rdata_a_o (rdata_a), .rdata_b_o (rdata_b), .rdata_c_o (rdata_c),
    .waddr_a_i (waddr_a), .wdata_a_i (wdata_a), .we_a_i (we_a),
    .waddr_b_i (waddr_b), .wdata_b_i (wdata_b), .we_b_i (we_b)
  );

  // ------------------------------------------------------------
  // Execute and write-back
  // ------------------------------------------------------------
  alu_execute #(.DATA_WIDTH(DATA_WIDTH)) u_execute (
    .clk_i (clk_int), .rst_n (rst_n),
    .op_valid_i (op_valid), .op_i (op), .rd_i (op_rd),
    .opa_i (rdata_a), .opb_i (rdata_b), .opc_i (rdata_c),
    .res_valid_o (res_valid), .res_rd_o (res_rd), .res_data_o (res_data)
  );

  result_writeback #(.DATA_WIDTH(DATA_WIDTH)) u_writeback (
    .clk_i (clk_int), .rst_n (rst_n),
    .res_valid_i (res_valid), .res_rd_i (res_rd), .res_data_i (res_data),
    .we_a_o (we_a), .waddr_a_o (waddr_a), .wdata_a_o (wdata_a),
    .last_result_o (last_result), .retire_count_o (retire_count),
    .wb_done_o (wb_done)
  );

endmodule

// File: tb/rfcop_tb_model.svh
// Reference model of the coprocessor for the testbench
// Register array, ALU rule, retire bookkeeping and typed compare tasks
`ifndef RFCOP_TB_MODEL_SVH
`define RFCOP_TB_MODEL_SVH

// ------------------------------------------------------------
// Model state
// ------------------------------------------------------------
// Entry 0 is never written, so it stays zero
logic [DATA_WIDTH-1:0] model_regs [0:31];
logic [DATA_WIDTH-1:0] model_last;
logic [DATA_WIDTH-1:0] model_count;

function automatic void model_reset();
  for (int i = 0; i < 32; i++)
    model_regs[i] = '0;
  model_last  = '0;
  model_count = '0;
endfunction

function automatic void model_write(input reg_addr_t idx, input logic [DATA_WIDTH-1:0] data);
  if (idx != 0)
    model_regs[idx] = data;
endfunction

// ALU rule, all arithmetic wraps at the data width
function automatic logic [DATA_WIDTH-1:0] model_alu(input op_t op,
                                                    input logic [DATA_WIDTH-1:0] a,
                                                    input logic [DATA_WIDTH-1:0] b,
                                                    input logic [DATA_WIDTH-1:0] c);
  case (op)
    3'd0:    return a + b;
    3'd1:    return a - b;
    3'd2:    return a & b;
    3'd3:    return a | b;
    3'd4:    return a ^ b;
    3'd5:    return a << b[4:0];
    3'd6:    return a + b + c;
    default: return c[0] ? a : b;
  endcase
endfunction

// Retired command, counted even when rd is 0
function automatic void model_retire(input reg_addr_t rd, input logic [DATA_WIDTH-1:0] res);
  model_write(rd, res);
  model_last  = res;
  model_count = model_count + 1'b1;
endfunction

// ------------------------------------------------------------
// Failure handling and compares
// ------------------------------------------------------------
task automatic abort_run();
  $display("tests failed");
  $fatal(1, "simulation stopped on first error");
endtask

task automatic fail_with_message(input string msg);
  $display("%s", msg);
  abort_run();
endtask

task automatic check_data(input string what, input logic [DATA_WIDTH-1:0] got,
                          input logic [DATA_WIDTH-1:0] exp);
  if (got !== exp)
  begin
    $display("ERR @%0t: %s read %h, expected %h", $time, what, got, exp);
    abort_run();
  end
endtask

task automatic check_addr_ok(input reg_addr_t idx, input logic [DATA_WIDTH-1:0] got,
                             input logic [DATA_WIDTH-1:0] exp);
  if (got !== exp)
  begin
    $display("ERR @%0t: register x%0d read %h, expected %h", $time, idx, got, exp);
    abort_run();
  end
endtask

`endif

// File: tb/rfcop_tb.sv
// Testbench for the register-file coprocessor
// Clock, reset, APB driver tasks, random direct writes and commands,
// unmapped address checks and a watchdog
module rfcop_tb import rfcop_pkg::*; ();

  localparam int DATA_WIDTH   = 32;
  localparam int NUM_WRITES   = 64;
  localparam int NUM_CMDS     = 300;
  localparam int NUM_UNMAPPED = 6;
  // Upper bound on APB accesses over the whole run
  localparam int NUM_OPS = 35 + NUM_WRITES * 2 + 32 + NUM_CMDS * 6 + NUM_UNMAPPED * 2 + 35;
  localparam int WATCHDOG_CYCLES = NUM_OPS * 12 + 200;

  logic                  clk_int;
  logic                  rst_n;
  logic                  test_en_i;
  apb_addr_t             paddr_i;
  logic                  psel_i;
  logic                  penable_i;
  logic                  pwrite_i;
  logic [DATA_WIDTH-1:0] pwdata_i;
  logic [DATA_WIDTH-1:0] prdata_o;
  logic                  pready_o;

  `include "rfcop_tb_model.svh"

  rfcop_top #(.DATA_WIDTH(DATA_WIDTH)) uut (
    .clk_int (clk_int), .rst_n (rst_n), .test_en_i (test_en_i),
    .paddr_i (paddr_i), .psel_i (psel_i), .penable_i (penable_i),
    .pwrite_i (pwrite_i), .pwdata_i (pwdata_i),
    .prdata_o (prdata_o), .pready_o (pready_o)
  );

  initial
    clk_int = 1'b0;

  always #5 clk_int = ~clk_int;

  // ------------------------------------------------------------
  // APB driver
  // ------------------------------------------------------------
  // Entered and left 1 unit after a rising edge, so accesses chain with no idle cycle
  task automatic apb_access(input apb_addr_t addr, input logic wr,
                            input logic [DATA_WIDTH-1:0] wdata,
                            output logic [DATA_WIDTH-1:0] rdata, output int waits);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    paddr_i   = addr;
    pwrite_i  = wr;
    pwdata_i  = wdata;
    @(posedge clk_int);
    #1 penable_i = 1'b1;
    waits = 0;
    // Sample PREADY and PRDATA mid-cycle
    @(negedge clk_int);
    while (!pready_o)
    begin
      waits++;
      @(negedge clk_int);
    end
    rdata = prdata_o;
    @(posedge clk_int);
    #1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  function automatic apb_addr_t reg_address(input reg_addr_t idx);
    return REG_BASE + {idx, 2'b00};
  endfunction

  // Command word from its fields
  function automatic logic [DATA_WIDTH-1:0] make_cmd(input op_t op, input reg_addr_t rd,
                                                     input reg_addr_t rs1, input reg_addr_t rs2,
                                                     input reg_addr_t rs3);
    logic [DATA_WIDTH-1:0] w;
    w        = '0;
    w[2:0]   = op;
    w[9:5]   = rd;
    w[14:10] = rs1;
    w[19:15] = rs2;
    w[24:20] = rs3;
    return w;
  endfunction

  // Issue one command and retire it in the model
  task automatic issue_cmd(input op_t op, input reg_addr_t rd, input reg_addr_t rs1,
                           input reg_addr_t rs2, input reg_addr_t rs3, output int waits);
    logic [DATA_WIDTH-1:0] res;
    logic [DATA_WIDTH-1:0] unused;
    res = model_alu(op, model_regs[rs1], model_regs[rs2], model_regs[rs3]);
    apb_access(ADDR_CMD, 1'b1, make_cmd(op, rd, rs1, rs2, rs3), unused, waits);
    model_retire(rd, res);
  endtask

  // First access after the command must stall, then see the result
  task automatic check_after_cmd(input reg_addr_t rd);
    logic [DATA_WIDTH-1:0] rdata;
    int                    waits;
    apb_access(reg_address(rd), 1'b0, '0, rdata, waits);
    if (waits == 0)
      fail_with_message("Read right after a command completed with pready_o never low");
    check_addr_ok(rd, rdata, model_regs[rd]);
    apb_access(ADDR_LAST, 1'b0, '0, rdata, waits);
    check_data("last result", rdata, model_last);
    apb_access(ADDR_COUNT, 1'b0, '0, rdata, waits);
    check_data("retire count", rdata, model_count);
  endtask

  // Whole register space plus status words
  task automatic check_all_regs();
    logic [DATA_WIDTH-1:0] rdata;
    int                    waits;
    for (int i = 0; i < 32; i++)
    begin
      apb_access(reg_address(reg_addr_t'(i)), 1'b0, '0, rdata, waits);
      check_addr_ok(reg_addr_t'(i), rdata, model_regs[i]);
    end
    apb_access(ADDR_LAST, 1'b0, '0, rdata, waits);
    check_data("last result", rdata, model_last);
    apb_access(ADDR_COUNT, 1'b0, '0, rdata, waits);
    check_data("retire count", rdata, model_count);
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial
  begin : stimulus
    logic [DATA_WIDTH-1:0] rdata;
    logic [DATA_WIDTH-1:0] data;
    int                    waits;
    reg_addr_t             idx;
    reg_addr_t             rd;
    reg_addr_t             rd2;
    apb_addr_t             unmapped [NUM_UNMAPPED];
    unmapped = '{12'h00c, 12'h010, 12'h0fc, 12'h101, 12'h180, 12'hffc};
    void'($urandom(32'h3c8c));
    test_en_i = 1'b0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    rst_n     = 1'b0;
    model_reset();
    repeat (4) @(posedge clk_int);
    #1 rst_n = 1'b1;
    @(negedge clk_int);
    if (!pready_o)
      fail_with_message("pready_o low after reset with no access pending");
    @(posedge clk_int);
    #1;
    check_all_regs();

    // Direct writes, every eighth one aimed at register 0
    for (int i = 0; i < NUM_WRITES; i++)
    begin
      idx  = (i % 8 == 0) ? reg_addr_t'(0) : reg_addr_t'($urandom());
      data = $urandom();
      apb_access(reg_address(idx), 1'b1, data, rdata, waits);
      model_write(idx, data);
      apb_access(reg_address(idx), 1'b0, '0, rdata, waits);
      check_addr_ok(idx, rdata, model_regs[idx]);
    end
    check_all_regs();

    // Commands with a fresh random operand before each one
    for (int n = 0; n < NUM_CMDS; n++)
    begin
      idx = reg_addr_t'($urandom());
      apb_access(reg_address(idx), 1'b1, $urandom(), rdata, waits);
      model_write(idx, pwdata_i);
      rd = reg_addr_t'($urandom());
      issue_cmd(op_t'(n % 8), rd, reg_addr_t'($urandom()), reg_addr_t'($urandom()),
                reg_addr_t'($urandom()), waits);
      // Dependent command straight after, rs1 is the previous rd
      if (n % 4 == 3)
      begin
        rd2 = reg_addr_t'($urandom());
        issue_cmd(op_t'($urandom()), rd2, rd, reg_addr_t'($urandom()),
                  reg_addr_t'($urandom()), waits);
        if (waits == 0)
          fail_with_message("Back-to-back command write saw pready_o high while busy");
        rd = rd2;
      end
      check_after_cmd(rd);
    end

    // Unmapped addresses read zero and ignore writes
    for (int i = 0; i < NUM_UNMAPPED; i++)
    begin
      apb_access(unmapped[i], 1'b1, $urandom(), rdata, waits);
      apb_access(unmapped[i], 1'b0, '0, rdata, waits);
      check_data("unmapped address", rdata, '0);
    end
    apb_access(ADDR_CMD, 1'b0, '0, rdata, waits);
    check_data("command address read", rdata, '0);
    check_all_regs();

    $display("all tests passed");
    $finish;
  end

  // Watchdog sized from the access count
  initial
  begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_int);
    $display("Timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    abort_run();
  end

endmodule

// File: rfcop.f
+incdir+tb
rtl/rfcop_pkg.sv
rtl/clock_gate.sv
rtl/register_file.sv
rtl/apb_cmd_decode.sv
rtl/alu_execute.sv
rtl/result_writeback.sv
rtl/rfcop_top.sv
tb/rfcop_tb.sv
